/* vlog.f */
logic/nc_pkg.sv
logic/nc_lane_split.sv
logic/nc_lane.sv
logic/nc_result_pack.sv
logic/nc_slice.sv
bench/nc_slice_assertions.sv
bench/nc_slice_tb.sv

/* Bender.yml */
package:
  name: nc_slice

sources:
  - files:
      - logic/nc_pkg.sv
      - logic/nc_lane_split.sv
      - logic/nc_lane.sv
      - logic/nc_result_pack.sv
      - logic/nc_slice.sv
  - target: test
    files:
      - bench/nc_slice_assertions.sv
      - bench/nc_slice_tb.sv

/* bench/nc_slice_tb.sv */
// Testbench for nc_slice with random stimulus, reference model, checks and report
module nc_slice_tb;

  import nc_pkg::*;

  localparam int unsigned SEED        = 32'ha2e3cbcb;
  localparam int          TOTAL_ITEMS = 1000;  // 200 + 200 + 200 + 300 + 100
  localparam int          CYCLE_LIMIT = 4 * TOTAL_ITEMS + 100;
  localparam int          M_SGNJ32    = 0;
  localparam int          M_SCALAR16  = 1;
  localparam int          M_VECTOR16  = 2;
  localparam int          M_BACKPRES  = 3;  // Random out_ready from here on
  localparam int          M_FLUSH     = 4;

  logic             clk = 1'b0;
  logic             rst_n;
  logic [1:0][31:0] operands;
  op_e              op;
  fmt_e             fmt;
  logic             vec, in_valid, in_ready, flush, out_valid, out_ready, busy;
  logic [3:0]       tag, out_tag, next_tag;
  logic [31:0]      result;
  status_t          status;
  int               errors, checks, cycle_count;
  logic [31:0]      exp_res[$];
  logic [4:0]       exp_stat[$];
  logic [3:0]       exp_tag[$];
  int               exp_edge[$];

  nc_slice nc_slice_inst (
    .clk_i (clk), .rst_n_i (rst_n), .operands_i (operands), .op_i (op), .fmt_i (fmt),
    .vectorial_op_i (vec), .tag_i (tag), .in_valid_i (in_valid), .in_ready_o (in_ready),
    .flush_i (flush), .result_o (result), .status_o (status), .tag_o (out_tag),
    .out_valid_o (out_valid), .out_ready_i (out_ready), .busy_o (busy)
  );

  bind nc_slice nc_slice_assertions assertions_inst (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i), .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i), .result_i (result_o), .status_i (status_o),
    .tag_i (tag_o), .busy_i (busy_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Order key for non-NaN values, -0 sorts just below +0
  function automatic logic [31:0] ordered_key(input logic sign, input logic [30:0] mag);
    if (sign) return 32'h7fff_ffff - {1'b0, mag};
    return 32'h8000_0000 + {1'b0, mag};
  endfunction

  // Invalid flag on top, lane result below
  function automatic logic [32:0] model_lane(input op_e o, input logic [31:0] a,
                                            input logic [31:0] b, input bit half);
    logic        sa, sb, na, nb, nv, sr;
    logic [30:0] ma, mb;
    logic [31:0] res, qnan;
    sa   = half ? a[15] : a[31];
    sb   = half ? b[15] : b[31];
    ma   = half ? {16'h0, a[14:0]} : a[30:0];
    mb   = half ? {16'h0, b[14:0]} : b[30:0];
    na   = half ? (&a[14:10] && |a[9:0]) : (&a[30:23] && |a[22:0]);
    nb   = half ? (&b[14:10] && |b[9:0]) : (&b[30:23] && |b[22:0]);
    nv   = half ? ((na && !a[9]) || (nb && !b[9])) : ((na && !a[22]) || (nb && !b[22]));
    qnan = half ? 32'h0000_7e00 : 32'h7fc0_0000;
    if (o == OP_MIN || o == OP_MAX) begin
      if (na && nb) res = qnan;
      else if (na) res = b;  // The number wins over a NaN
      else if (nb) res = a;
      else if (o == OP_MIN) res = (ordered_key(sa, ma) < ordered_key(sb, mb)) ? a : b;
      else res = (ordered_key(sa, ma) > ordered_key(sb, mb)) ? a : b;
    end else begin
      sr  = (o == OP_SGNJ) ? sb : ((o == OP_SGNJN) ? !sb : sa ^ sb);
      res = half ? {16'h0, sr, ma[14:0]} : {sr, ma};
      nv  = 1'b0;
    end
    return {nv, res};
  endfunction

  // Status on top, packed word below
  function automatic logic [36:0] expect_word(input op_e o, input fmt_e f, input logic v,
                                             input logic [1:0][31:0] ops);
    logic [32:0] lo, hi;
    lo = model_lane(o, ops[0], ops[1], f == FMT_FP16);
    hi = model_lane(o, ops[0] >> 16, ops[1] >> 16, 1'b1);
    if (f == FMT_FP32) return {lo[32], 4'b0, lo[31:0]};
    if (v) return {lo[32] | hi[32], 4'b0, hi[15:0], lo[15:0]};
    return {lo[32], 4'b0, 16'hffff, lo[15:0]};  // Scalar result is NaN-boxed
  endfunction

  // Random value biased toward NaNs, infinities and signed zeros
  function automatic logic [31:0] pick_value(input bit half);
    logic [31:0] r;
    r = $urandom;
    case ($urandom_range(7, 0))
      0: return half ? {r[15], 5'h1f, 1'b1, r[8:0]} : {r[31], 8'hff, 1'b1, r[21:0]};
      1: return half ? {r[15], 5'h1f, 1'b0, r[8:1], 1'b1} : {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      2: return half ? {r[15], 15'h7c00} : {r[31], 31'h7f80_0000};
      3: return half ? {r[15], 15'h0} : {r[31], 31'h0};
      default: return r;
    endcase
  endfunction

  // ----------------------------------------
  // Stimulus and checks
  // ----------------------------------------
  task automatic load_item(input int mode);
    logic [31:0] up, dn;
    op  = op_e'((mode == M_SGNJ32) ? $urandom_range(2, 0) : $urandom_range(4, 0));
    fmt = (mode == M_SGNJ32) ? FMT_FP32 : fmt_e'($urandom_range(1, 0));
    fmt = (mode == M_SCALAR16 || mode == M_VECTOR16) ? FMT_FP16 : fmt;
    vec = (mode >= M_BACKPRES) ? $urandom_range(1, 0) : (mode == M_VECTOR16);
    for (int i = 0; i < 2; i++) begin
      up = pick_value(fmt == FMT_FP16);
      dn = pick_value(fmt == FMT_FP16);
      operands[i] = (fmt == FMT_FP16) ? {up[15:0], dn[15:0]} : dn;
    end
    tag = next_tag;
  endtask

  task automatic check_output(input string name, input bit exact);
    int lat;
    if (exp_res.size() == 0) begin
      errors++;
      $display("%s: output with tag %h appeared while no item was in flight", name, out_tag);
    end else begin
      lat = cycle_count - exp_edge.pop_front();
      checks += 3;
      if (out_tag != exp_tag[0])
        $display("ERR %s tag expected %h actual %h", name, exp_tag[0], out_tag);
      if (result != exp_res[0])
        $display("ERR %s result expected %h actual %h", name, exp_res[0], result);
      if (status != exp_stat[0])
        $display("ERR %s status expected %b actual %b", name, exp_stat[0], status);
      if (out_tag != exp_tag[0] || result != exp_res[0] || status != exp_stat[0]) errors++;
      if (exact ? (lat != 2) : (lat < 2)) begin
        errors++;
        $display("%s: tag %h left after %0d cycles instead of 2", name, out_tag, lat);
      end
      void'(exp_tag.pop_front());
      void'(exp_res.pop_front());
      void'(exp_stat.pop_front());
    end
  endtask

  task automatic run_test(input string name, input int n_items, input int mode);
    int          sent, err_start;
    bit          pending, flushed, idle_check;
    logic [36:0] exp;
    sent       = 0;
    pending    = 0;
    flushed    = 0;
    idle_check = 0;
    err_start  = errors;
    while (sent < n_items || pending || exp_res.size() > 0) begin
      @(negedge clk);
      if (!pending && sent < n_items && $urandom_range(3, 0) != 0) begin
        load_item(mode);
        pending = 1;
      end
      in_valid  = pending;
      out_ready = (mode >= M_BACKPRES) ? $urandom_range(1, 0) : 1'b1;
      flush     = !flushed && mode == M_FLUSH && sent >= n_items / 2 && exp_res.size() > 0;
      if (flush) begin
        in_valid  = 1'b0;  // Nothing moves in the flush cycle
        out_ready = 1'b0;
        flushed   = 1;
      end
      #1;
      if (idle_check && (busy || out_valid)) begin
        errors++;
        $display("%s: pipeline still busy one cycle after the flush", name);
      end
      idle_check = flush;
      if (flush) begin
        exp_res.delete();
        exp_stat.delete();
        exp_tag.delete();
        exp_edge.delete();
      end
      if (in_valid && in_ready) begin
        exp = expect_word(op, fmt, vec, operands);
        exp_res.push_back(exp[31:0]);
        exp_stat.push_back(exp[36:32]);
        exp_tag.push_back(tag);
        exp_edge.push_back(cycle_count);
        next_tag++;
        sent++;
        pending = 0;
      end
      if (out_valid && out_ready) check_output(name, mode < M_BACKPRES);
    end
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b0;
    $display("%s: %0d items accepted, %0d errors", name, sent, errors - err_start);
  endtask

  initial begin
    void'($urandom(SEED));
    {rst_n, in_valid, out_ready, flush, vec} = '0;
    operands    = '0;
    op          = OP_SGNJ;
    fmt         = FMT_FP32;
    tag         = '0;
    next_tag    = '0;
    {errors, checks, cycle_count} = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (!in_ready || out_valid || busy) begin
      errors++;
      $display("Reset state wrong: in_ready %b out_valid %b busy %b", in_ready, out_valid, busy);
    end
    run_test("fp32_sgnj", 200, M_SGNJ32);
    run_test("fp16_scalar", 200, M_SCALAR16);
    run_test("fp16_vector", 200, M_VECTOR16);
    run_test("backpressure", 300, M_BACKPRES);
    run_test("flush", 100, M_FLUSH);
    errors += nc_slice_inst.assertions_inst.fail_count;  // Concurrent checks count too
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* bench/nc_slice_assertions.sv */
// Concurrent checks on reset, output hold under back-pressure and busy
module nc_slice_assertions (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     flush_i,
  input logic                     out_valid_i,
  input logic                     out_ready_i,
  input logic [nc_pkg::WIDTH-1:0] result_i,
  input nc_pkg::status_t          status_i,
  input logic [nc_pkg::TAG_W-1:0] tag_i,
  input logic                     busy_i
);

  int fail_count = 0;  // Failed assertions so far

  // ----------------------------------------
  // Reset and output stability
  // ----------------------------------------
  valid_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
      fail_count++;
      $error("out_valid high in the cycle after reset");
    end

  // A flush may drop lane 1 and with it part of the status
  hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=>
      $stable(result_i) && $stable(status_i) && $stable(tag_i))
    else begin
      fail_count++;
      $error("output changed while stalled");
    end

  busy_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i |-> busy_i)
    else begin
      fail_count++;
      $error("busy low while an output is valid");
    end

endmodule

/* logic/nc_slice.sv */
// Top level of the two-lane FP non-computational slice with valid/ready handshake
module nc_slice (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [nc_pkg::NUM_OPERANDS-1:0][nc_pkg::WIDTH-1:0] operands_i,
  input  nc_pkg::op_e                                         op_i,
  input  nc_pkg::fmt_e                                        fmt_i,
  input  logic                                                vectorial_op_i,
  input  logic [nc_pkg::TAG_W-1:0]                            tag_i,
  input  logic                                                in_valid_i,
  output logic                                                in_ready_o,
  input  logic                                                flush_i,
  output logic [nc_pkg::WIDTH-1:0]                            result_o,
  output nc_pkg::status_t                                     status_o,
  output logic [nc_pkg::TAG_W-1:0]                            tag_o,
  output logic                                                out_valid_o,
  input  logic                                                out_ready_i,
  output logic                                                busy_o
);

  import nc_pkg::*;

  logic                            advance;       // Whole pipeline moves one step
  logic [NUM_LANES-1:0][WIDTH-1:0] lane_a;
  logic [NUM_LANES-1:0][WIDTH-1:0] lane_b;
  logic [NUM_LANES-1:0]            lane_in_valid;
  logic [NUM_LANES-1:0][WIDTH-1:0] lane_result;
  status_t [NUM_LANES-1:0]         lane_status;
  logic [NUM_LANES-1:0]            lane_valid;
  logic [NUM_LANES-1:0]            lane_busy;
  logic [NUM_LANES-1:0]            lane_vector;
  logic [TAG_W-1:0]                lane_tag [NUM_LANES];  // Only lane 0 is read
  fmt_e                            lane_fmt [NUM_LANES];

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  assign advance    = ~lane_valid[0] | out_ready_i;  // Last stage empty or drained
  assign in_ready_o = advance;

  nc_lane_split split_inst (
    .operands_i     (operands_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .in_valid_i     (in_valid_i),
    .lane_a_o       (lane_a),
    .lane_b_o       (lane_b),
    .lane_valid_o   (lane_in_valid)
  );

  // Lane 0 handles FP32 too, lane 1 only the upper FP16 element
  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lanes
    nc_lane #(
      .HasFp32 (l == 0)
    ) lane_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .a_i       (lane_a[l]),
      .b_i       (lane_b[l]),
      .op_i      (op_i),
      .fmt_i     (fmt_i),
      .tag_i     (tag_i),
      .vector_i  (vectorial_op_i),
      .valid_i   (lane_in_valid[l]),
      .advance_i (advance),
      .flush_i   (flush_i),
      .result_o  (lane_result[l]),
      .status_o  (lane_status[l]),
      .tag_o     (lane_tag[l]),
      .fmt_o     (lane_fmt[l]),
      .vector_o  (lane_vector[l]),
      .valid_o   (lane_valid[l]),
      .busy_o    (lane_busy[l])
    );
  end

  nc_result_pack pack_inst (
    .lane0_result_i (lane_result[0]),
    .lane1_result_i (lane_result[1]),
    .lane_valid_i   (lane_valid),
    .lane0_status_i (lane_status[0]),
    .lane1_status_i (lane_status[1]),
    .fmt_i          (lane_fmt[0]),
    .vector_i       (lane_vector[0]),
    .result_o       (result_o),
    .status_o       (status_o)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  assign out_valid_o = lane_valid[0];  // Master lane
  assign tag_o       = lane_tag[0];
  assign busy_o      = |lane_busy;

endmodule

/* logic/nc_result_pack.sv */
// Output stage packing lane results by format with NaN-boxing and status collapse
module nc_result_pack (
  input  logic [nc_pkg::WIDTH-1:0]     lane0_result_i,
  input  logic [nc_pkg::WIDTH-1:0]     lane1_result_i,
  input  logic [nc_pkg::NUM_LANES-1:0] lane_valid_i,
  input  nc_pkg::status_t              lane0_status_i,
  input  nc_pkg::status_t              lane1_status_i,
  input  nc_pkg::fmt_e                 fmt_i,
  input  logic                         vector_i,
  output logic [nc_pkg::WIDTH-1:0]     result_o,
  output nc_pkg::status_t              status_o
);

  import nc_pkg::*;

  localparam int unsigned BOX_W = WIDTH - FP16_W;

  // ----------------------------------------
  // Result packing
  // ----------------------------------------
  always_comb begin : pack_result
    if (fmt_i == FMT_FP32) begin
      result_o = lane0_result_i;  // Whole word from the master lane
    end else if (vector_i) begin
      result_o = {lane1_result_i[FP16_W-1:0], lane0_result_i[FP16_W-1:0]};
    end else begin
      // Scalar FP16 is NaN-boxed
      result_o = {{BOX_W{1'b1}}, lane0_result_i[FP16_W-1:0]};
    end
  end

  // ----------------------------------------
  // Status collapse
  // ----------------------------------------
  always_comb begin : collapse_status
    status_o = '0;
    if (lane_valid_i[0]) status_o = status_o | lane0_status_i;
    if (lane_valid_i[1]) status_o = status_o | lane1_status_i;  // Idle lane adds nothing
  end

endmodule

/* logic/nc_lane.sv */
// Single FP lane with sign injection, min/max datapath and output pipeline
module nc_lane #(
  parameter bit HasFp32 = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [nc_pkg::WIDTH-1:0] a_i,
  input  logic [nc_pkg::WIDTH-1:0] b_i,
  input  nc_pkg::op_e              op_i,
  input  nc_pkg::fmt_e             fmt_i,
  input  logic [nc_pkg::TAG_W-1:0] tag_i,
  input  logic                     vector_i,
  input  logic                     valid_i,
  input  logic                     advance_i,
  input  logic                     flush_i,
  output logic [nc_pkg::WIDTH-1:0] result_o,
  output nc_pkg::status_t          status_o,
  output logic [nc_pkg::TAG_W-1:0] tag_o,
  output nc_pkg::fmt_e             fmt_o,
  output logic                     vector_o,
  output logic                     valid_o,
  output logic                     busy_o
);

  import nc_pkg::*;

  localparam int unsigned BOX_W = WIDTH - FP16_W;

  // ----------------------------------------
  // Field decoding helpers
  // ----------------------------------------
  function automatic logic is_nan(input logic [WIDTH-1:0] v, input logic half);
    if (half) return (&v[FP16_W-2 -: EXP16_W]) && (|v[MAN16_W-1:0]);
    return (&v[WIDTH-2 -: EXP32_W]) && (|v[MAN32_W-1:0]);
  endfunction

  // Quiet bit clear marks a signaling NaN
  function automatic logic is_snan(input logic [WIDTH-1:0] v, input logic half);
    if (half) return is_nan(v, half) && !v[MAN16_W-1];
    return is_nan(v, half) && !v[MAN32_W-1];
  endfunction

  function automatic logic [WIDTH-2:0] magnitude(input logic [WIDTH-1:0] v, input logic half);
    logic [WIDTH-2:0] m;
    m = '0;
    if (half) m[FP16_W-2:0] = v[FP16_W-2:0];
    else m = v[WIDTH-2:0];
    return m;
  endfunction

  logic             half;              // Operate on FP16 fields
  logic             sign_a, sign_b;
  logic             nan_a, nan_b;
  logic             snan_a, snan_b;
  logic [WIDTH-2:0] mag_a, mag_b;
  logic             a_lt_b;            // Total order, -0 below +0
  logic             sign_res;
  logic [WIDTH-1:0] box_a, box_b;      // Operands NaN-boxed for FP16
  logic [WIDTH-1:0] qnan;
  logic [WIDTH-1:0] op_res;
  status_t          op_status;

  // Pipeline stages, index 0 is the combinational input
  logic [WIDTH-1:0] res_pipe    [0:NUM_PIPE_REGS];
  status_t          status_pipe [0:NUM_PIPE_REGS];
  logic [TAG_W-1:0] tag_pipe    [0:NUM_PIPE_REGS];
  fmt_e             fmt_pipe    [0:NUM_PIPE_REGS];
  logic             vector_pipe [0:NUM_PIPE_REGS];
  logic             valid_pipe  [0:NUM_PIPE_REGS];

  assign half = (fmt_i == FMT_FP16) || !HasFp32;  // Upper lane is FP16 only

  // ----------------------------------------
  // Operation datapath
  // ----------------------------------------
  always_comb begin : datapath
    sign_a = half ? a_i[FP16_W-1] : a_i[WIDTH-1];
    sign_b = half ? b_i[FP16_W-1] : b_i[WIDTH-1];
    nan_a  = is_nan(a_i, half);
    nan_b  = is_nan(b_i, half);
    snan_a = is_snan(a_i, half);
    snan_b = is_snan(b_i, half);
    mag_a  = magnitude(a_i, half);
    mag_b  = magnitude(b_i, half);

    if (sign_a != sign_b) a_lt_b = sign_a;  // Negative side is smaller
    else if (sign_a) a_lt_b = mag_a > mag_b;
    else a_lt_b = mag_a < mag_b;

    box_a = half ? {{BOX_W{1'b1}}, a_i[FP16_W-1:0]} : a_i;
    box_b = half ? {{BOX_W{1'b1}}, b_i[FP16_W-1:0]} : b_i;
    qnan  = half ? {{BOX_W{1'b1}}, QNAN_FP16} : QNAN_FP32;

    case (op_i)
      OP_SGNJ:  sign_res = sign_b;
      OP_SGNJN: sign_res = ~sign_b;
      OP_SGNJX: sign_res = sign_a ^ sign_b;
      default:  sign_res = sign_a;
    endcase

    op_status = '0;
    case (op_i)
      OP_MIN, OP_MAX: begin
        op_status.nv = snan_a | snan_b;
        if (nan_a && nan_b) op_res = qnan;
        else if (nan_a) op_res = box_b;   // Non-NaN operand wins
        else if (nan_b) op_res = box_a;
        else if ((op_i == OP_MIN) == a_lt_b) op_res = box_a;
        else op_res = box_b;
      end
      default: begin
        if (half) op_res = {{BOX_W{1'b1}}, sign_res, a_i[FP16_W-2:0]};
        else op_res = {sign_res, a_i[WIDTH-2:0]};
      end
    endcase
  end

  // ----------------------------------------
  // Output pipeline
  // ----------------------------------------
  assign res_pipe[0]    = op_res;
  assign status_pipe[0] = op_status;
  assign tag_pipe[0]    = tag_i;
  assign fmt_pipe[0]    = fmt_i;
  assign vector_pipe[0] = vector_i;
  assign valid_pipe[0]  = valid_i;

  for (genvar i = 0; i < NUM_PIPE_REGS; i++) begin : gen_pipe
    always_ff @(posedge clk_i) begin : valid_reg
      if (!rst_n_i || flush_i) begin
        valid_pipe[i+1] <= 1'b0;
      end else if (advance_i) begin
        valid_pipe[i+1] <= valid_pipe[i];
      end
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (advance_i) begin
        res_pipe[i+1]    <= res_pipe[i];
        status_pipe[i+1] <= status_pipe[i];
        tag_pipe[i+1]    <= tag_pipe[i];
        fmt_pipe[i+1]    <= fmt_pipe[i];
        vector_pipe[i+1] <= vector_pipe[i];
      end
    end
  end

  assign result_o = res_pipe[NUM_PIPE_REGS];
  assign status_o = status_pipe[NUM_PIPE_REGS];
  assign tag_o    = tag_pipe[NUM_PIPE_REGS];
  assign fmt_o    = fmt_pipe[NUM_PIPE_REGS];
  assign vector_o = vector_pipe[NUM_PIPE_REGS];
  assign valid_o  = valid_pipe[NUM_PIPE_REGS];

  // Any stage holding an item
  always_comb begin : busy_or
    busy_o = 1'b0;
    for (int i = 1; i <= NUM_PIPE_REGS; i++) begin
      busy_o |= valid_pipe[i];
    end
  end

endmodule

/* logic/nc_lane_split.sv */
// Input stage slicing operands into per-lane words and gating lane valids
module nc_lane_split (
  input  logic [nc_pkg::NUM_OPERANDS-1:0][nc_pkg::WIDTH-1:0] operands_i,
  input  nc_pkg::fmt_e                                        fmt_i,
  input  logic                                                vectorial_op_i,
  input  logic                                                in_valid_i,
  output logic [nc_pkg::NUM_LANES-1:0][nc_pkg::WIDTH-1:0]    lane_a_o,
  output logic [nc_pkg::NUM_LANES-1:0][nc_pkg::WIDTH-1:0]    lane_b_o,
  output logic [nc_pkg::NUM_LANES-1:0]                        lane_valid_o
);

  import nc_pkg::*;

  logic vector_fp16;  // Both lanes carry FP16 elements

  assign vector_fp16 = (fmt_i == FMT_FP16) && vectorial_op_i;

  // ----------------------------------------
  // Operand slicing
  // ----------------------------------------
  // Lane 0 sees the full words and picks its field by format.
  // Lane 1 only ever works on the upper FP16 element
  always_comb begin : slice_operands
    lane_a_o[0] = operands_i[0];
    lane_b_o[0] = operands_i[1];
    lane_a_o[1] = operands_i[0] >> FP16_W;  // Upper half moved down
    lane_b_o[1] = operands_i[1] >> FP16_W;
  end

  // ----------------------------------------
  // Lane valids
  // ----------------------------------------
  assign lane_valid_o[0] = in_valid_i;                // Master lane always runs
  assign lane_valid_o[1] = in_valid_i & vector_fp16;  // Only for FP16 vectors

endmodule

/* logic/nc_pkg.sv */
// Shared widths, formats, operation codes, status flags and canonical NaNs
package nc_pkg;

  // ----------------------------------------
  // Datapath dimensions
  // ----------------------------------------
  localparam int unsigned WIDTH         = 32;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_OPERANDS  = 2;  // Operand A at index 0, B at index 1
  localparam int unsigned FP16_W        = 16;
  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned TAG_W         = 4;

  // Exponent and mantissa field widths
  localparam int unsigned EXP32_W = 8;
  localparam int unsigned MAN32_W = 23;
  localparam int unsigned EXP16_W = 5;
  localparam int unsigned MAN16_W = 10;

  // ----------------------------------------
  // Formats and operations
  // ----------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fmt_e;

  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,  // Sign taken from B
    OP_SGNJN = 3'd1,  // Negated sign of B
    OP_SGNJX = 3'd2,  // Sign of A xor sign of B
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } op_e;

  // IEEE 754 exception flags, only nv can fire in this group
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // Canonical quiet NaNs
  localparam logic [WIDTH-1:0]  QNAN_FP32 = 32'h7fc0_0000;
  localparam logic [FP16_W-1:0] QNAN_FP16 = 16'h7e00;

endpackage
